// File: compile.f
source/harness_pkg.sv
source/reset_seq.sv
source/debug_delay_timer.sv
source/bus_router.sv
source/boot_rom.sv
source/dram_model.sv
source/host_exit.sv
source/harness_top.sv
test/tb_harness_top.sv

// File: run_sim.sh
#!/bin/sh
# Build the harness testbench with Verilator, run it and scan the log

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --assert -j 0 --top-module tb_harness_top -Mdir obj_dir -f compile.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vtb_harness_top > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^No errors$" "$LOG"; then
  exit 0
fi
echo "Pass message not found in $LOG"
exit 1

// File: test/tb_harness_top.sv
// Harness testbench
// Drives the memory bus of the harness top level and keeps a reference model
// of reset timing, debug gating, DRAM bytes and the exit register; all
// outputs are compared shortly after every rising edge

module tb_harness_top;

  // Stimulus runs for under 200 cycles
  localparam int unsigned MaxCycles = 2000;

  logic                  clk_i;
  logic                  rst_ni;
  logic                  ndmreset;
  logic                  debug_req;
  harness_pkg::mem_req_t bus_req;
  harness_pkg::mem_rsp_t bus_rsp;
  logic                  sys_ready;
  logic                  debug_gated;
  logic [31:0]           exit_code;
  logic                  exit_valid;

  // Reference model state
  logic                  exp_ready;
  int                    hold_left;
  int unsigned           dbg_cnt;
  harness_pkg::mem_rsp_t exp_rsp;
  logic [63:0]           dram_ref [harness_pkg::DramWords];
  logic [63:0]           host_word;
  logic [31:0]           exp_exit;
  logic                  exp_exit_valid;
  int unsigned           errors = 0;
  int unsigned           cycle_count = 0;

  harness_top u_harness_top (
    .clk_i        ( clk_i       ),
    .rst_ni       ( rst_ni      ),
    .ndmreset_i   ( ndmreset    ),
    .debug_req_i  ( debug_req   ),
    .bus_req_i    ( bus_req     ),
    .bus_rsp_o    ( bus_rsp     ),
    .sys_ready_o  ( sys_ready   ),
    .debug_req_o  ( debug_gated ),
    .exit_o       ( exit_code   ),
    .exit_valid_o ( exit_valid  )
  );

  initial begin : clock_gen
    clk_i = 1'b0;
    forever begin
      #5 clk_i = ~clk_i;
    end
  end

  always @(posedge clk_i) begin : cycle_limit
    cycle_count++;
    if (cycle_count >= MaxCycles) begin
      $display("Timeout: run did not finish within %0d cycles", MaxCycles);
      $display("Errors found");
      $fatal(1);
    end
  end

  // --------------------------------------------------------------------------
  // Reference model
  // --------------------------------------------------------------------------
  function automatic harness_pkg::region_e decode_region(input logic [31:0] addr);
    if (addr >= harness_pkg::RomBase &&
        addr < harness_pkg::RomBase + 32'(harness_pkg::RomWords * 8)) begin
      return harness_pkg::RegionRom;
    end else if (addr >= harness_pkg::DramBase &&
                 addr < harness_pkg::DramBase + 32'(harness_pkg::DramWords * 8)) begin
      return harness_pkg::RegionDram;
    end else if (addr[31:3] == harness_pkg::HostBase[31:3]) begin
      return harness_pkg::RegionHost;
    end
    return harness_pkg::RegionNone;
  endfunction

  always @(posedge clk_i) begin : ref_model
    logic                 was_ready;
    harness_pkg::region_e region;
    logic [63:0]          rdata;
    int unsigned          idx;
    was_ready = exp_ready;
    region    = decode_region(bus_req.addr);
    rdata     = '0;
    // Ready on the 3rd edge after release, 2 edges after a debug reset
    if (!rst_ni) begin
      exp_ready = 1'b0;
      hold_left = harness_pkg::ResetHoldCycles + 1;
    end else if (exp_ready && ndmreset) begin
      exp_ready = 1'b0;
      hold_left = harness_pkg::ResetHoldCycles;
    end else if (!exp_ready) begin
      hold_left = hold_left - 1;
      exp_ready = (hold_left == 0);
    end
    exp_rsp = '0;
    if (rst_ni && was_ready && bus_req.req) begin
      case (region)
        harness_pkg::RegionRom: begin
          if (!bus_req.we) begin
            idx   = (bus_req.addr - harness_pkg::RomBase) >> 3;
            rdata = {harness_pkg::RomMagic, 32'(idx)};
          end
        end
        harness_pkg::RegionDram: begin
          idx = (bus_req.addr - harness_pkg::DramBase) >> 3;
          if (bus_req.we) begin
            for (int b = 0; b < 8; b++) begin
              if (bus_req.be[b]) begin
                dram_ref[idx][b*8 +: 8] = bus_req.wdata[b*8 +: 8];
              end
            end
          end else begin
            rdata = dram_ref[idx];
          end
        end
        harness_pkg::RegionHost: begin
          if (bus_req.we) begin
            host_word = bus_req.wdata;
            if (bus_req.wdata[0]) begin
              exp_exit       = bus_req.wdata[32:1];
              exp_exit_valid = 1'b1;
            end
          end else begin
            rdata = host_word;
          end
        end
        default: begin
          if (!bus_req.we) begin
            rdata = harness_pkg::DecErrData;
          end
        end
      endcase
      exp_rsp.rvalid = 1'b1;
      exp_rsp.err    = (region == harness_pkg::RegionNone);
      exp_rsp.rdata  = rdata;
    end
    // System reset clears the response, the exit register and the debug window
    if (!exp_ready) begin
      exp_rsp        = '0;
      host_word      = '0;
      exp_exit       = '0;
      exp_exit_valid = 1'b0;
      dbg_cnt        = harness_pkg::DebugDelayCycles;
    end else if (was_ready && dbg_cnt != 0) begin
      dbg_cnt = dbg_cnt - 1;
    end
  end

  // --------------------------------------------------------------------------
  // Checking
  // --------------------------------------------------------------------------
  task automatic check_equal(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    assert (actual === expected) else begin
      errors++;
      $display("ERROR at time %0t: %s expected %h actual %h", $time, name, expected, actual);
      $display("Errors found");
      $fatal(1);
    end
  endtask

  // Outputs have settled two time units after the edge
  always @(posedge clk_i) begin : output_check
    #2;
    check_equal("bus_rsp_o.rvalid", 64'(exp_rsp.rvalid), 64'(bus_rsp.rvalid));
    check_equal("bus_rsp_o.err", 64'(exp_rsp.err), 64'(bus_rsp.err));
    check_equal("bus_rsp_o.rdata", exp_rsp.rdata, bus_rsp.rdata);
    check_equal("sys_ready_o", 64'(exp_ready), 64'(sys_ready));
    check_equal("debug_req_o", 64'(debug_req && dbg_cnt == 0), 64'(debug_gated));
    check_equal("exit_o", 64'(exp_exit), 64'(exit_code));
    check_equal("exit_valid_o", 64'(exp_exit_valid), 64'(exit_valid));
  end

  // --------------------------------------------------------------------------
  // Stimulus tasks, called on a falling edge
  // --------------------------------------------------------------------------
  task automatic bus_access(input logic we, input logic [31:0] addr,
                            input logic [7:0] be, input logic [63:0] wdata);
    bus_req.req   = 1'b1;
    bus_req.we    = we;
    bus_req.addr  = addr;
    bus_req.be    = be;
    bus_req.wdata = wdata;
    @(negedge clk_i);
  endtask

  task automatic idle_cycles(input int n);
    bus_req = '0;
    repeat (n) @(negedge clk_i);
  endtask

  task automatic wait_ready();
    bus_req = '0;
    do begin
      @(negedge clk_i);
    end while (!sys_ready);
  endtask

  initial begin : stimulus
    int unsigned word;
    logic [63:0] data;
    logic [31:0] code;
    void'($urandom(13));
    rst_ni         = 1'b0;
    ndmreset       = 1'b0;
    debug_req      = 1'b1;
    bus_req        = '0;
    exp_ready      = 1'b0;
    hold_left      = harness_pkg::ResetHoldCycles + 1;
    dbg_cnt        = harness_pkg::DebugDelayCycles;
    exp_rsp        = '0;
    host_word      = '0;
    exp_exit       = '0;
    exp_exit_valid = 1'b0;
    for (int i = 0; i < harness_pkg::DramWords; i++) begin
      dram_ref[i] = '0;
    end
    repeat (4) @(negedge clk_i);
    rst_ni = 1'b1;
    wait_ready();
    idle_cycles(20);

    // Debug reset pulse
    ndmreset = 1'b1;
    idle_cycles(1);
    ndmreset = 1'b0;
    // Only the last of these DRAM writes arrives after the hold
    for (int i = 0; i < 3; i++) begin
      bus_access(1'b1, harness_pkg::DramBase + 32'((32 + i) * 8), '1, '1);
    end
    wait_ready();
    idle_cycles(20);

    for (int i = 0; i < harness_pkg::RomWords; i++) begin
      bus_access(1'b0, harness_pkg::RomBase + 32'(i * 8), '1, '0);
    end

    // DRAM writes to a small window so words get overwritten
    for (int i = 0; i < 48; i++) begin
      word      = $urandom % 32;
      data      = {$urandom, $urandom};
      debug_req = 1'($urandom);
      bus_access(1'b1, harness_pkg::DramBase + 32'(word * 8), 8'($urandom), data);
    end
    debug_req = 1'b1;
    // Window plus the three words written around the debug reset hold
    for (int i = 0; i < 35; i++) begin
      bus_access(1'b0, harness_pkg::DramBase + 32'(i * 8), '1, '0);
    end
    for (int i = 0; i < 12; i++) begin
      word = $urandom % 32;
      bus_access(1'b1, harness_pkg::DramBase + 32'(word * 8), 8'($urandom),
                 {$urandom, $urandom});
      bus_access(1'b0, harness_pkg::DramBase + 32'(word * 8), '1, '0);
    end

    // Unmapped reads and a write whose low bits alias DRAM word 2
    bus_access(1'b0, 32'h0000_0000, '1, '0);
    bus_access(1'b0, 32'h4000_0000, '1, '0);
    bus_access(1'b0, harness_pkg::DramBase + 32'(harness_pkg::DramWords * 8), '1, '0);
    bus_access(1'b1, 32'h4000_0010, '1, {$urandom, $urandom});
    bus_access(1'b0, harness_pkg::DramBase + 32'h10, '1, '0);

    code = $urandom;
    bus_access(1'b1, harness_pkg::HostBase, '1, 64'h0000_0000_0000_00A4);
    bus_access(1'b0, harness_pkg::HostBase, '1, '0);
    bus_access(1'b1, harness_pkg::HostBase, '1, {31'b0, code, 1'b1});
    bus_access(1'b0, harness_pkg::HostBase, '1, '0);
    idle_cycles(4);

    if (errors == 0) begin
      $display("No errors");
      $finish;
    end else begin
      $display("Errors found");
      $fatal(1);
    end
  end

endmodule

// File: source/harness_top.sv
// Harness top level
// Reset sequencer, debug delay timer, bus router and the three bus targets
// behind a single-beat memory bus port

module harness_top (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  ndmreset_i,
  input  logic                  debug_req_i,
  input  harness_pkg::mem_req_t bus_req_i,
  output harness_pkg::mem_rsp_t bus_rsp_o,
  output logic                  sys_ready_o,
  output logic                  debug_req_o,
  output logic [31:0]           exit_o,
  output logic                  exit_valid_o
);

  logic                              sys_rst_n;
  harness_pkg::mem_req_t             bus_req_run;
  harness_pkg::mem_req_t             tgt_req;
  logic                              rom_req;
  logic                              dram_req;
  logic                              host_req;
  logic [harness_pkg::DataWidth-1:0] rom_rdata;
  logic [harness_pkg::DataWidth-1:0] dram_rdata;
  logic [harness_pkg::DataWidth-1:0] host_rdata;

  // --------------------------------------------------------------------------
  // Reset and debug gating
  // --------------------------------------------------------------------------
  reset_seq u_reset_seq (
    .clk_i      ( clk_i      ),
    .rst_ni     ( rst_ni     ),
    .ndmreset_i ( ndmreset_i ),
    .sys_rst_no ( sys_rst_n  )
  );

  debug_delay_timer u_debug_delay_timer (
    .clk_i       ( clk_i       ),
    .rst_ni      ( sys_rst_n   ),
    .debug_req_i ( debug_req_i ),
    .debug_req_o ( debug_req_o )
  );

  assign sys_ready_o = sys_rst_n;

  // Requests only count once the system runs
  always_comb begin
    bus_req_run     = bus_req_i;
    bus_req_run.req = bus_req_i.req & sys_rst_n;
  end

  // --------------------------------------------------------------------------
  // Bus decode and targets
  // --------------------------------------------------------------------------
  bus_router u_bus_router (
    .clk_i        ( clk_i       ),
    .rst_ni       ( sys_rst_n   ),
    .req_i        ( bus_req_run ),
    .rsp_o        ( bus_rsp_o   ),
    .rom_req_o    ( rom_req     ),
    .dram_req_o   ( dram_req    ),
    .host_req_o   ( host_req    ),
    .tgt_req_o    ( tgt_req     ),
    .rom_rdata_i  ( rom_rdata   ),
    .dram_rdata_i ( dram_rdata  ),
    .host_rdata_i ( host_rdata  )
  );

  boot_rom u_boot_rom (
    .clk_i   ( clk_i        ),
    .req_i   ( rom_req      ),
    .addr_i  ( tgt_req.addr ),
    .rdata_o ( rom_rdata    )
  );

  dram_model u_dram_model (
    .clk_i   ( clk_i         ),
    .req_i   ( dram_req      ),
    .we_i    ( tgt_req.we    ),
    .addr_i  ( tgt_req.addr  ),
    .be_i    ( tgt_req.be    ),
    .wdata_i ( tgt_req.wdata ),
    .rdata_o ( dram_rdata    )
  );

  host_exit u_host_exit (
    .clk_i        ( clk_i         ),
    .rst_ni       ( sys_rst_n     ),
    .req_i        ( host_req      ),
    .we_i         ( tgt_req.we    ),
    .wdata_i      ( tgt_req.wdata ),
    .rdata_o      ( host_rdata    ),
    .exit_o       ( exit_o        ),
    .exit_valid_o ( exit_valid_o  )
  );

endmodule

// File: source/host_exit.sv
// Host exit register
// Captures the exit word written by the program; bit 0 marks the write as
// an exit and bits 32:1 carry the exit code

module host_exit (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  input  logic                               req_i,
  input  logic                               we_i,
  input  logic [harness_pkg::DataWidth-1:0]  wdata_i,
  output logic [harness_pkg::DataWidth-1:0]  rdata_o,
  output logic [31:0]                        exit_o,
  output logic                               exit_valid_o
);

  logic [harness_pkg::DataWidth-1:0] word_q;
  logic [harness_pkg::DataWidth-1:0] rdata_q;
  logic [31:0]                       exit_q;
  logic                              exit_valid_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      word_q       <= '0;
      rdata_q      <= '0;
      exit_q       <= '0;
      exit_valid_q <= 1'b0;
    end else if (req_i && we_i) begin
      word_q <= wdata_i;
      // Exit flag stays set until the next system reset
      if (wdata_i[0]) begin
        exit_q       <= wdata_i[32:1];
        exit_valid_q <= 1'b1;
      end
    end else if (req_i) begin
      rdata_q <= word_q;
    end
  end

  assign rdata_o      = rdata_q;
  assign exit_o       = exit_q;
  assign exit_valid_o = exit_valid_q;

endmodule

// File: source/dram_model.sv
// DRAM model
// Word-addressed RAM with byte enables and a registered read port

module dram_model (
  input  logic                               clk_i,
  input  logic                               req_i,
  input  logic                               we_i,
  input  logic [harness_pkg::AddrWidth-1:0]  addr_i,
  input  logic [harness_pkg::StrbWidth-1:0]  be_i,
  input  logic [harness_pkg::DataWidth-1:0]  wdata_i,
  output logic [harness_pkg::DataWidth-1:0]  rdata_o
);

  logic [harness_pkg::DataWidth-1:0]    mem_q [harness_pkg::DramWords];
  logic [harness_pkg::DramIdxWidth-1:0] word_idx;
  logic [harness_pkg::DataWidth-1:0]    rdata_q;

  // Base is aligned, so the low address bits index the array directly
  assign word_idx = addr_i[harness_pkg::WordOffset +: harness_pkg::DramIdxWidth];

  // Unwritten words read as zero
  initial begin
    for (int i = 0; i < harness_pkg::DramWords; i++) begin
      mem_q[i] = '0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_i && we_i) begin
      for (int b = 0; b < harness_pkg::StrbWidth; b++) begin
        if (be_i[b]) begin
          mem_q[word_idx][b*8 +: 8] <= wdata_i[b*8 +: 8];
        end
      end
    end else if (req_i) begin
      rdata_q <= mem_q[word_idx];
    end
  end

  assign rdata_o = rdata_q;

endmodule

// File: source/boot_rom.sv
// Boot ROM
// Fixed word table, each word holds the magic tag and its own index;
// read data is registered one cycle after the request

module boot_rom (
  input  logic                               clk_i,
  input  logic                               req_i,
  input  logic [harness_pkg::AddrWidth-1:0]  addr_i,
  output logic [harness_pkg::DataWidth-1:0]  rdata_o
);

  logic [harness_pkg::RomIdxWidth-1:0] rom_idx;
  logic [harness_pkg::DataWidth-1:0]   rdata_q;

  // Word index, wraps within the ROM size
  assign rom_idx = addr_i[harness_pkg::WordOffset +: harness_pkg::RomIdxWidth];

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      rdata_q <= {harness_pkg::RomMagic, 32'(rom_idx)};
    end
  end

  assign rdata_o = rdata_q;

endmodule

// File: source/bus_router.sv
// Memory bus router
// Decodes each request address into a target region, steers the request
// strobe to that target and builds the response one cycle later

module bus_router (
  input  logic                                     clk_i,
  input  logic                                     rst_ni,
  input  harness_pkg::mem_req_t                    req_i,
  output harness_pkg::mem_rsp_t                    rsp_o,
  output logic                                     rom_req_o,
  output logic                                     dram_req_o,
  output logic                                     host_req_o,
  output harness_pkg::mem_req_t                    tgt_req_o,
  input  logic [harness_pkg::DataWidth-1:0]        rom_rdata_i,
  input  logic [harness_pkg::DataWidth-1:0]        dram_rdata_i,
  input  logic [harness_pkg::DataWidth-1:0]        host_rdata_i
);

  harness_pkg::region_e region_d, region_q;
  logic                 valid_q;
  logic                 we_q;
  logic [harness_pkg::DataWidth-1:0] sel_rdata;

  // --------------------------------------------------------------------------
  // Address decode
  // --------------------------------------------------------------------------
  always_comb begin
    if (req_i.addr >= harness_pkg::RomBase &&
        req_i.addr < harness_pkg::RomBase + harness_pkg::RomWords * harness_pkg::StrbWidth) begin
      region_d = harness_pkg::RegionRom;
    end else if (req_i.addr >= harness_pkg::DramBase &&
                 req_i.addr < harness_pkg::DramBase +
                              harness_pkg::DramWords * harness_pkg::StrbWidth) begin
      region_d = harness_pkg::RegionDram;
    end else if (req_i.addr[harness_pkg::AddrWidth-1:harness_pkg::WordOffset] ==
                 harness_pkg::HostBase[harness_pkg::AddrWidth-1:harness_pkg::WordOffset]) begin
      region_d = harness_pkg::RegionHost;
    end else begin
      region_d = harness_pkg::RegionNone;
    end
  end

  assign rom_req_o  = req_i.req & (region_d == harness_pkg::RegionRom);
  assign dram_req_o = req_i.req & (region_d == harness_pkg::RegionDram);
  assign host_req_o = req_i.req & (region_d == harness_pkg::RegionHost);
  // Targets only look at the shared fields, the strobes above qualify them
  assign tgt_req_o  = req_i;

  // --------------------------------------------------------------------------
  // Response path
  // --------------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q  <= 1'b0;
      we_q     <= 1'b0;
      region_q <= harness_pkg::RegionNone;
    end else begin
      valid_q  <= req_i.req;
      we_q     <= req_i.we;
      region_q <= region_d;
    end
  end

  always_comb begin
    unique case (region_q)
      harness_pkg::RegionRom:  sel_rdata = rom_rdata_i;
      harness_pkg::RegionDram: sel_rdata = dram_rdata_i;
      harness_pkg::RegionHost: sel_rdata = host_rdata_i;
      harness_pkg::RegionNone: sel_rdata = harness_pkg::DecErrData;
    endcase
  end

  // Write responses carry no data
  assign rsp_o.rvalid = valid_q;
  assign rsp_o.err    = valid_q & (region_q == harness_pkg::RegionNone);
  assign rsp_o.rdata  = (valid_q && !we_q) ? sel_rdata : '0;

endmodule

// File: source/debug_delay_timer.sv
// Debug delay timer
// Blocks debug requests for a fixed window after system reset release,
// giving boot code time to run before the first halt

module debug_delay_timer (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic debug_req_i,
  output logic debug_req_o
);

  logic [harness_pkg::DebugCntWidth-1:0] cnt_q;
  logic                                  gate_open;

  assign gate_open = (cnt_q == '0);

  // Loaded while in reset, saturates at zero
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= harness_pkg::DebugCntWidth'(harness_pkg::DebugDelayCycles);
    end else if (!gate_open) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  assign debug_req_o = debug_req_i & gate_open;

endmodule

// File: source/reset_seq.sv
// Reset sequencer
// Holds the system in reset for two cycles after power-on reset or after a
// debug-module reset request, then releases it through a registered output

module reset_seq (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic ndmreset_i,
  output logic sys_rst_no
);

  harness_pkg::reset_state_e state_d, state_q;
  logic                      sys_rst_q;

  // Next state
  always_comb begin
    state_d = state_q;
    unique case (state_q)
      harness_pkg::StReset: state_d = harness_pkg::StHold1;
      harness_pkg::StHold1: state_d = harness_pkg::StHold2;
      harness_pkg::StHold2: state_d = harness_pkg::StRun;
      harness_pkg::StRun: begin
        // Debug reset request restarts the hold sequence
        if (ndmreset_i) begin
          state_d = harness_pkg::StHold1;
        end
      end
    endcase
  end

  // Output follows the next state, so it lines up with the state register
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= harness_pkg::StReset;
      sys_rst_q <= 1'b0;
    end else begin
      state_q   <= state_d;
      sys_rst_q <= (state_d == harness_pkg::StRun);
    end
  end

  assign sys_rst_no = sys_rst_q;

endmodule

// File: source/harness_pkg.sv
// Harness package
// Bus widths, address map and timing constants for the simulation harness,
// plus the memory bus request and response structs

package harness_pkg;

  // --------------------------------------------------------------------------
  // Bus geometry
  // --------------------------------------------------------------------------
  localparam int unsigned AddrWidth  = 32;
  localparam int unsigned DataWidth  = 64;
  localparam int unsigned StrbWidth  = DataWidth / 8;
  localparam int unsigned WordOffset = $clog2(StrbWidth);

  // --------------------------------------------------------------------------
  // Address map
  // --------------------------------------------------------------------------
  localparam logic [AddrWidth-1:0] RomBase     = 32'h0000_1000;
  localparam int unsigned          RomWords    = 16;
  localparam int unsigned          RomIdxWidth = $clog2(RomWords);

  localparam logic [AddrWidth-1:0] DramBase     = 32'h8000_0000;
  localparam int unsigned          DramWords    = 256;
  localparam int unsigned          DramIdxWidth = $clog2(DramWords);

  // Single word, exit code in bits 32:1
  localparam logic [AddrWidth-1:0] HostBase = 32'h0000_2000;

  localparam logic [31:0]          RomMagic   = 32'hB007_0000;
  localparam logic [DataWidth-1:0] DecErrData = 64'hDEAD_BEEF_DEAD_BEEF;

  // --------------------------------------------------------------------------
  // Timing
  // --------------------------------------------------------------------------
  // Matches the two hold states of the reset sequencer
  localparam int unsigned ResetHoldCycles  = 2;
  localparam int unsigned DebugDelayCycles = 16;
  localparam int unsigned DebugCntWidth    = $clog2(DebugDelayCycles + 1);

  typedef enum logic [1:0] {
    RegionRom,
    RegionDram,
    RegionHost,
    RegionNone
  } region_e;

  typedef enum logic [1:0] {
    StReset,
    StHold1,
    StHold2,
    StRun
  } reset_state_e;

  typedef struct packed {
    logic                 req;
    logic                 we;
    logic [AddrWidth-1:0] addr;
    logic [StrbWidth-1:0] be;
    logic [DataWidth-1:0] wdata;
  } mem_req_t;

  typedef struct packed {
    logic                 rvalid;
    logic                 err;
    logic [DataWidth-1:0] rdata;
  } mem_rsp_t;

endpackage
